// File: common/xosvm_pkg.sv
/*
 * Shared types and constants of the XOSVM memory virtualization unit.
 * Compile this package before any module of the unit.
 * Modules reach its contents through a wildcard import in their header.
 */

package xosvm_pkg;

    ////////////////////
    // Vector types
    ////////////////////

    // Address or data word
    typedef logic [31:0] addr_t;
    // CSR address space
    typedef logic [11:0] csr_addr_t;
    // One enable per byte lane
    typedef logic [3:0]  byte_en_t;

    ////////////////////
    // Enums
    ////////////////////

    // Encoding follows the RISC-V privilege spec
    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b00,
        CSR_SET   = 2'b01,
        CSR_CLEAR = 2'b10
    } csr_op_e;

    // Cause held by the fault record
    typedef enum logic [1:0] {
        FAULT_NONE  = 2'b00,
        FAULT_FETCH = 2'b01,
        FAULT_LOAD  = 2'b10,
        FAULT_STORE = 2'b11
    } fault_cause_e;

    ////////////////////
    // Structs
    ////////////////////

    // One virtual region as seen by an MMU
    typedef struct packed {
        addr_t offset;
        addr_t size;
        addr_t mask;
    } region_cfg_t;

    // Data access as issued by the core
    typedef struct packed {
        logic     read_en;
        byte_en_t write_en;
        addr_t    address;
    } mem_req_t;

    // Translated address plus bound check result
    typedef struct packed {
        addr_t address;
        logic  fault;
    } mmu_res_t;

    ////////////////////
    // CSR map
    ////////////////////

    localparam csr_addr_t CSR_MVMCTL = 12'h7C0;
    localparam csr_addr_t CSR_MVMDO  = 12'h7C1;
    localparam csr_addr_t CSR_MVMDS  = 12'h7C2;
    localparam csr_addr_t CSR_MVMDM  = 12'h7C3;
    localparam csr_addr_t CSR_MVMIO  = 12'h7C4;
    localparam csr_addr_t CSR_MVMIS  = 12'h7C5;
    localparam csr_addr_t CSR_MVMIM  = 12'h7C6;

    // Masks open the whole address space out of reset
    localparam addr_t MASK_RESET = 32'hFFFF_FFFF;

endpackage

// File: logic/mem_access_gate.sv
/*
 * Memory access gate behind the two MMUs.
 * Enables the memory operation for unkilled, in-bound accesses and keeps
 * the cause and untranslated address of the last access fault.
 */

module mem_access_gate
    import xosvm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,

    // Access from the core
    input  mem_req_t     req_i,
    input  logic         killed_i,

    // MMU results
    input  mmu_res_t     fetch_res_i,
    input  addr_t        fetch_addr_i,
    input  mmu_res_t     data_res_i,

    // Memory side
    output logic         mem_op_en_o,
    output byte_en_t     mem_we_o,

    // Fault record
    output fault_cause_e fault_cause_o,
    output addr_t        fault_addr_o
);

    // Read or any byte lane written
    logic req_active;
    // Data fault on a real access
    logic data_fault;
    // Store if any lane is written
    logic is_store;

    fault_cause_e cause_q;
    addr_t        addr_q;

    ////////////////////
    // Enable
    ////////////////////

    assign req_active = req_i.read_en || (req_i.write_en != '0);
    assign is_store   = (req_i.write_en != '0);
    // Idle cycles never count as data faults
    assign data_fault = req_active && data_res_i.fault;

    assign mem_op_en_o = !killed_i && req_active && !data_res_i.fault;
    assign mem_we_o    = req_i.write_en;

    ////////////////////
    // Fault record
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cause_q <= FAULT_NONE;
            addr_q  <= '0;
        end
        else if (!killed_i) begin
            // Data side has priority over fetch
            if (data_fault) begin
                cause_q <= is_store ? FAULT_STORE : FAULT_LOAD;
                addr_q  <= req_i.address;
            end
            else if (fetch_res_i.fault) begin
                cause_q <= FAULT_FETCH;
                addr_q  <= fetch_addr_i;
            end
        end
    end

    // Held until the next recorded fault
    assign fault_cause_o = cause_q;
    assign fault_addr_o  = addr_q;

endmodule

// File: logic/region_mmu.sv
/*
 * Base and bound MMU for one virtual region.
 * Masks the address, checks it against the region size and relocates it
 * by the region offset. Purely combinational, used for fetch and data.
 */

module region_mmu
    import xosvm_pkg::*;
(
    // Translation enable
    input  logic        en_i,
    // Region offset, size and mask
    input  region_cfg_t cfg_i,
    // Virtual address
    input  addr_t       addr_i,
    // Physical address and fault flag
    output mmu_res_t    res_o
);

    // Address limited to the region window
    addr_t masked_addr;
    // Address beyond the region size
    logic  out_of_bound;
    // Address moved into physical space
    addr_t reloc_addr;

    ////////////////////
    // Translation
    ////////////////////

    assign masked_addr = addr_i & cfg_i.mask;

    // Size acts as an exclusive upper bound
    assign out_of_bound = (masked_addr >= cfg_i.size);

    // Wraps around on overflow like the core adder
    assign reloc_addr = masked_addr + cfg_i.offset;

    ////////////////////
    // Result
    ////////////////////

    always_comb begin
        if (en_i) begin
            res_o.address = reloc_addr;
            res_o.fault   = out_of_bound;
        end
        else begin
            // Bypass keeps the physical address as is
            res_o.address = addr_i;
            res_o.fault   = 1'b0;
        end
    end

endmodule

// File: logic/xosvm_unit.sv
/*
 * Top level of the XOSVM memory virtualization path.
 * Connects the CSR bank, the fetch and data MMUs and the access gate.
 * XOSVM_EN set to 0 keeps both MMUs in bypass.
 */

module xosvm_unit
    import xosvm_pkg::*;
#(
    parameter bit XOSVM_EN = 1'b1
)
(
    input  logic         clk,
    input  logic         rst_n_i,

    // CSR access
    input  logic         csr_we_i,
    input  csr_op_e      csr_op_i,
    input  csr_addr_t    csr_addr_i,
    input  addr_t        csr_wdata_i,
    input  csr_addr_t    csr_raddr_i,
    output addr_t        csr_rdata_o,

    // Current privilege level
    input  priv_e        priv_i,

    // Instruction fetch
    input  addr_t        fetch_addr_i,
    output addr_t        fetch_addr_o,
    output logic         fetch_fault_o,

    // Data access
    input  mem_req_t     data_req_i,
    input  logic         killed_i,
    output addr_t        mem_addr_o,
    output logic         mem_op_en_o,
    output byte_en_t     mem_we_o,

    // Last access fault
    output fault_cause_e fault_cause_o,
    output addr_t        fault_addr_o
);

    ////////////////////
    // Internal wires
    ////////////////////

    logic        mmu_on;
    region_cfg_t i_cfg;
    region_cfg_t d_cfg;
    mmu_res_t    fetch_res;
    mmu_res_t    data_res;

    ////////////////////
    // CSR bank
    ////////////////////

    xosvm_csr_bank #(
        .XOSVM_EN    (XOSVM_EN)
    ) u_csr_bank (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .csr_we_i    (csr_we_i),
        .csr_op_i    (csr_op_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o),
        .priv_i      (priv_i),
        .mmu_on_o    (mmu_on),
        .i_cfg_o     (i_cfg),
        .d_cfg_o     (d_cfg)
    );

    ////////////////////
    // MMUs
    ////////////////////

    // Instruction side
    region_mmu u_fetch_mmu (
        .en_i   (mmu_on),
        .cfg_i  (i_cfg),
        .addr_i (fetch_addr_i),
        .res_o  (fetch_res)
    );

    // Data side
    region_mmu u_data_mmu (
        .en_i   (mmu_on),
        .cfg_i  (d_cfg),
        .addr_i (data_req_i.address),
        .res_o  (data_res)
    );

    assign fetch_addr_o  = fetch_res.address;
    assign fetch_fault_o = fetch_res.fault;
    assign mem_addr_o    = data_res.address;

    ////////////////////
    // Access gate
    ////////////////////

    mem_access_gate u_gate (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .req_i         (data_req_i),
        .killed_i      (killed_i),
        .fetch_res_i   (fetch_res),
        .fetch_addr_i  (fetch_addr_i),
        .data_res_i    (data_res),
        .mem_op_en_o   (mem_op_en_o),
        .mem_we_o      (mem_we_o),
        .fault_cause_o (fault_cause_o),
        .fault_addr_o  (fault_addr_o)
    );

endmodule

// File: verification/xosvm_unit_chk.sv
/*
 * Concurrent assertions on the XOSVM top level.
 * Bound into xosvm_unit, they watch the memory enable, the MMU bypass
 * path and the fault record right after reset.
 */

module xosvm_unit_chk
    import xosvm_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         killed_i,
    input  logic         mmu_on_i,
    input  mem_req_t     data_req_i,
    input  addr_t        mem_addr_i,
    input  logic         mem_op_en_i,
    input  fault_cause_e fault_cause_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int fail_count = 0;

    ////////////////////
    // Properties
    ////////////////////

    // A killed access never reaches memory
    a_no_killed_access: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mem_op_en_i |-> !killed_i
    ) else begin
        fail_count++;
        $error("Memory enable raised on a killed access");
    end

    // Bypass keeps the data address
    a_bypass_addr: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !mmu_on_i |-> (mem_addr_i == data_req_i.address)
    ) else begin
        fail_count++;
        $error("Data address changed while the MMU is off");
    end

    // Fault record cleared by reset
    a_reset_fault: assert property (
        @(posedge clk)
        !rst_n_i |=> (fault_cause_i == FAULT_NONE)
    ) else begin
        fail_count++;
        $error("Fault cause not cleared after reset");
    end

endmodule

// File: verification/xosvm_unit_tb.sv
/*
 * Testbench of the XOSVM unit.
 * Drives random CSR traffic, fetches and data accesses from an LCG and
 * compares every DUT output with a reference model kept in the testbench.
 */

module xosvm_unit_tb
    import xosvm_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int N_CSR        = 620;
    localparam int N_ROUNDS     = 4;
    localparam int N_MMU        = 200;
    localparam int N_GATE       = 260;
    // Reset reads and CSR traffic followed by rounds of region setup plus accesses
    localparam int TEST_CYCLES  = 8 + N_CSR + N_ROUNDS * (8 + N_MMU + N_GATE);
    localparam int TIMEOUT      = RESET_CYCLES + TEST_CYCLES + 200;

    logic         clk;
    logic         rst_n_i;
    logic         csr_we_i;
    csr_op_e      csr_op_i;
    csr_addr_t    csr_addr_i;
    addr_t        csr_wdata_i;
    csr_addr_t    csr_raddr_i;
    addr_t        csr_rdata_o;
    priv_e        priv_i;
    addr_t        fetch_addr_i;
    addr_t        fetch_addr_o;
    logic         fetch_fault_o;
    mem_req_t     data_req_i;
    logic         killed_i;
    addr_t        mem_addr_o;
    logic         mem_op_en_o;
    byte_en_t     mem_we_o;
    fault_cause_e fault_cause_o;
    addr_t        fault_addr_o;

    // Model CSRs in map order
    addr_t        m_csr [0:6];
    fault_cause_e m_cause;
    addr_t        m_fault_addr;

    logic [31:0]  lcg_state;
    int           error_count;
    int           cycle_count = 0;

    xosvm_unit #(.XOSVM_EN(1'b1)) u_xosvm_unit (.*);

    bind xosvm_unit xosvm_unit_chk u_chk (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .killed_i      (killed_i),
        .mmu_on_i      (mmu_on),
        .data_req_i    (data_req_i),
        .mem_addr_i    (mem_addr_o),
        .mem_op_en_i   (mem_op_en_o),
        .fault_cause_i (fault_cause_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Two LCG steps whose upper halves form one word
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic priv_e rand_priv();
        case (next_rand() % 3)
            0: return USER;
            1: return SUPERVISOR;
            default: return MACHINE;
        endcase
    endfunction

    // Expected fault flag on top of the expected address
    function automatic logic [32:0] model_mmu(logic on, addr_t off, addr_t size,
                                              addr_t mask, addr_t va);
        addr_t masked;
        masked = va & mask;
        if (!on)
            return {1'b0, va};
        return {masked >= size, masked + off};
    endfunction

    function automatic addr_t model_read(csr_addr_t a);
        if (a >= 12'h7C0 && a <= 12'h7C6)
            return m_csr[a - 12'h7C0];
        return '0;
    endfunction

    task automatic report_error(string test, string sig, logic [31:0] exp, logic [31:0] act);
        error_count++;
        $display("[ERROR] %s %s expected %h actual %h at %0t", test, sig, exp, act, $time);
    endtask

    task automatic drive_csr(csr_addr_t a, csr_op_e op, addr_t wdata);
        csr_we_i    = 1'b1;
        csr_addr_i  = a;
        csr_op_i    = op;
        csr_wdata_i = wdata;
    endtask

    // Random fetch and data access with strobes and kill only in gate mode
    task automatic drive_access(bit gate_mode);
        fetch_addr_i       = next_rand();
        data_req_i.address = next_rand();
        priv_i             = rand_priv();
        csr_raddr_i        = CSR_MVMCTL + csr_addr_t'(next_rand() % 7);
        if (gate_mode) begin
            data_req_i.read_en  = (next_rand() % 2) == 1;
            data_req_i.write_en = ((next_rand() % 2) == 1) ? byte_en_t'(next_rand()) : '0;
            killed_i            = (next_rand() % 4) == 0;
        end
        else begin
            data_req_i.read_en  = 1'b1;
            data_req_i.write_en = '0;
            killed_i            = 1'b0;
        end
    endtask

    // One cycle from edge plus 2 ns to the next edge plus 2 ns
    task automatic step(string name);
        logic [32:0] f_exp;
        logic [32:0] d_exp;
        addr_t       rd_exp;
        logic        on_exp;
        logic        active;
        logic        en_exp;
        int          idx;
        on_exp = m_csr[0][0] && (priv_i != MACHINE);
        f_exp  = model_mmu(on_exp, m_csr[4], m_csr[5], m_csr[6], fetch_addr_i);
        d_exp  = model_mmu(on_exp, m_csr[1], m_csr[2], m_csr[3], data_req_i.address);
        rd_exp = model_read(csr_raddr_i);
        active = data_req_i.read_en || (data_req_i.write_en != '0);
        en_exp = !killed_i && active && !d_exp[32];
        #10;
        if (csr_rdata_o !== rd_exp)
            report_error(name, "csr_rdata_o", rd_exp, csr_rdata_o);
        if (fetch_addr_o !== f_exp[31:0])
            report_error(name, "fetch_addr_o", f_exp[31:0], fetch_addr_o);
        if (fetch_fault_o !== f_exp[32])
            report_error(name, "fetch_fault_o", f_exp[32], fetch_fault_o);
        if (mem_addr_o !== d_exp[31:0])
            report_error(name, "mem_addr_o", d_exp[31:0], mem_addr_o);
        if (mem_op_en_o !== en_exp)
            report_error(name, "mem_op_en_o", en_exp, mem_op_en_o);
        if (mem_we_o !== data_req_i.write_en)
            report_error(name, "mem_we_o", data_req_i.write_en, mem_we_o);
        @(posedge clk);
        // Fault record with the data side first
        if (!killed_i && active && d_exp[32]) begin
            if (data_req_i.write_en != '0)
                m_cause = FAULT_STORE;
            else
                m_cause = FAULT_LOAD;
            m_fault_addr = data_req_i.address;
        end
        else if (!killed_i && f_exp[32]) begin
            m_cause      = FAULT_FETCH;
            m_fault_addr = fetch_addr_i;
        end
        if (csr_we_i && csr_addr_i >= CSR_MVMCTL && csr_addr_i <= CSR_MVMIM) begin
            idx = csr_addr_i - CSR_MVMCTL;
            case (csr_op_i)
                CSR_WRITE: m_csr[idx] = csr_wdata_i;
                CSR_SET:   m_csr[idx] = m_csr[idx] | csr_wdata_i;
                default:   m_csr[idx] = m_csr[idx] & ~csr_wdata_i;
            endcase
        end
        #2;
        if (fault_cause_o !== m_cause)
            report_error(name, "fault_cause_o", m_cause, fault_cause_o);
        if (fault_addr_o !== m_fault_addr)
            report_error(name, "fault_addr_o", m_fault_addr, fault_addr_o);
    endtask

    // Narrow masks and sizes so accesses land both inside and outside
    task automatic setup_regions(bit mmu_enable);
        drive_csr(CSR_MVMDM, CSR_WRITE, 32'h0003_FFFF >> (next_rand() % 4));
        step("region_setup");
        drive_csr(CSR_MVMDS, CSR_WRITE, next_rand() & 32'h0001_FFFF);
        step("region_setup");
        drive_csr(CSR_MVMDO, CSR_WRITE, next_rand());
        step("region_setup");
        drive_csr(CSR_MVMIM, CSR_WRITE, 32'h0003_FFFF >> (next_rand() % 4));
        step("region_setup");
        drive_csr(CSR_MVMIS, CSR_WRITE, next_rand() & 32'h0001_FFFF);
        step("region_setup");
        drive_csr(CSR_MVMIO, CSR_WRITE, next_rand());
        step("region_setup");
        drive_csr(CSR_MVMCTL, CSR_WRITE, {31'b0, mmu_enable});
        step("region_setup");
        csr_we_i = 1'b0;
        step("region_setup");
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        csr_addr_t waddr;
        csr_addr_t last_waddr;
        int        sel;
        int        assert_fails;
        lcg_state    = 32'd62174;
        error_count  = 0;
        rst_n_i      = 1'b0;
        csr_we_i     = 1'b0;
        csr_op_i     = CSR_WRITE;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        csr_raddr_i  = '0;
        priv_i       = MACHINE;
        fetch_addr_i = '0;
        data_req_i   = '0;
        killed_i     = 1'b0;
        last_waddr   = CSR_MVMCTL;
        for (int i = 0; i < 7; i++)
            m_csr[i] = '0;
        m_csr[3]     = MASK_RESET;
        m_csr[6]     = MASK_RESET;
        m_cause      = FAULT_NONE;
        m_fault_addr = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // Reset values with one unmapped address at the end
        for (int i = 0; i < 8; i++) begin
            csr_raddr_i = CSR_MVMCTL + csr_addr_t'(i);
            step("reset_read");
        end

        // Random write, set and clear read back one cycle later
        for (int i = 0; i < N_CSR; i++) begin
            csr_raddr_i = last_waddr;
            sel = next_rand() % 10;
            if (sel == 9)
                waddr = csr_addr_t'(next_rand());
            else
                waddr = CSR_MVMCTL + csr_addr_t'(sel);
            drive_csr(waddr, csr_op_e'(next_rand() % 3), next_rand());
            csr_we_i   = (next_rand() % 4) != 0;
            priv_i     = rand_priv();
            last_waddr = waddr;
            step("csr_random");
        end

        // Last round runs with translation off
        for (int r = 0; r < N_ROUNDS; r++) begin
            setup_regions(r != N_ROUNDS - 1);
            for (int i = 0; i < N_MMU; i++) begin
                drive_access(1'b0);
                step("mmu_translate");
            end
            for (int i = 0; i < N_GATE; i++) begin
                drive_access(1'b1);
                step("gate_fault");
            end
        end

        assert_fails = u_xosvm_unit.u_chk.fail_count;
        $display("Run complete with %0d check errors and %0d assertion failures",
                 error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end
        else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: xosvm_csr/xosvm_csr_bank.sv
/*
 * Virtualization CSRs of the XOSVM extension.
 * Seven registers at 0x7C0 to 0x7C6 with write, set and clear updates
 * and a combinational read port. Also derives the MMU enable level.
 */

module xosvm_csr_bank
    import xosvm_pkg::*;
#(
    parameter bit XOSVM_EN = 1'b1
)
(
    input  logic        clk,
    input  logic        rst_n_i,

    // Write port
    input  logic        csr_we_i,
    input  csr_op_e     csr_op_i,
    input  csr_addr_t   csr_addr_i,
    input  addr_t       csr_wdata_i,

    // Read port
    input  csr_addr_t   csr_raddr_i,
    output addr_t       csr_rdata_o,

    input  priv_e       priv_i,

    // Region setup towards the MMUs
    output logic        mmu_on_o,
    output region_cfg_t i_cfg_o,
    output region_cfg_t d_cfg_o
);

    ////////////////////
    // Registers
    ////////////////////

    addr_t mvmctl;
    // Data region
    addr_t mvmdo;
    addr_t mvmds;
    addr_t mvmdm;
    // Instruction region
    addr_t mvmio;
    addr_t mvmis;
    addr_t mvmim;

    // New value of a CSR under the requested operation
    function automatic addr_t apply_op(csr_op_e op, addr_t cur, addr_t wdata);
        addr_t result;
        case (op)
            CSR_WRITE: result = wdata;
            CSR_SET:   result = cur | wdata;
            CSR_CLEAR: result = cur & ~wdata;
            // Reserved encoding keeps the old value
            default:   result = cur;
        endcase
        return result;
    endfunction

    ////////////////////
    // Update
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mvmctl <= '0;
            mvmdo  <= '0;
            mvmds  <= '0;
            mvmdm  <= MASK_RESET;
            mvmio  <= '0;
            mvmis  <= '0;
            mvmim  <= MASK_RESET;
        end
        else if (csr_we_i) begin
            // Only the addressed CSR changes
            case (csr_addr_i)
                CSR_MVMCTL: mvmctl <= apply_op(csr_op_i, mvmctl, csr_wdata_i);
                CSR_MVMDO:  mvmdo  <= apply_op(csr_op_i, mvmdo,  csr_wdata_i);
                CSR_MVMDS:  mvmds  <= apply_op(csr_op_i, mvmds,  csr_wdata_i);
                CSR_MVMDM:  mvmdm  <= apply_op(csr_op_i, mvmdm,  csr_wdata_i);
                CSR_MVMIO:  mvmio  <= apply_op(csr_op_i, mvmio,  csr_wdata_i);
                CSR_MVMIS:  mvmis  <= apply_op(csr_op_i, mvmis,  csr_wdata_i);
                CSR_MVMIM:  mvmim  <= apply_op(csr_op_i, mvmim,  csr_wdata_i);
                // Addresses outside the map are dropped
                default: begin
                end
            endcase
        end
    end

    ////////////////////
    // Read
    ////////////////////

    always_comb begin
        case (csr_raddr_i)
            CSR_MVMCTL: csr_rdata_o = mvmctl;
            CSR_MVMDO:  csr_rdata_o = mvmdo;
            CSR_MVMDS:  csr_rdata_o = mvmds;
            CSR_MVMDM:  csr_rdata_o = mvmdm;
            CSR_MVMIO:  csr_rdata_o = mvmio;
            CSR_MVMIS:  csr_rdata_o = mvmis;
            CSR_MVMIM:  csr_rdata_o = mvmim;
            // Unmapped reads return zero
            default:    csr_rdata_o = '0;
        endcase
    end

    ////////////////////
    // MMU control
    ////////////////////

    // Machine mode always sees physical addresses
    assign mmu_on_o = XOSVM_EN && mvmctl[0] && (priv_i != MACHINE);

    // Instruction side
    assign i_cfg_o.offset = mvmio;
    assign i_cfg_o.size   = mvmis;
    assign i_cfg_o.mask   = mvmim;

    // Data side
    assign d_cfg_o.offset = mvmdo;
    assign d_cfg_o.size   = mvmds;
    assign d_cfg_o.mask   = mvmdm;

endmodule

// File: xosvm_unit.f
common/xosvm_pkg.sv
xosvm_csr/xosvm_csr_bank.sv
logic/region_mmu.sv
logic/mem_access_gate.sv
logic/xosvm_unit.sv
verification/xosvm_unit_chk.sv
verification/xosvm_unit_tb.sv
